//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // packet handed to decode.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        fault;
    } fetch_packet_t;

    // read address channel payload.
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // read data channel payload.
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    // sdram window, A000_0000 up to BFFF_FFFF.
    localparam logic [3:0] SDRAM_BASE_NIBBLE = 4'hA;
    localparam logic [3:0] SDRAM_END_NIBBLE  = 4'hB;

    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;

    // four byte beats.
    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h3000_0000
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // execute side.
    input  wire logic                  redirect_valid,
    input  wire logic [31:0]           redirect_pc,

    // decode side.
    input  wire logic                  fetch_ready,
    output logic                       fetch_valid,
    output fetch_pkg::fetch_packet_t   fetch_pkt,

    // cache lookup.
    output logic [31:0]                lookup_addr,
    input  wire logic                  lookup_hit,
    input  wire logic [31:0]           lookup_inst,
    input  wire logic                  lookup_fault
);
    import fetch_pkg::*;

    logic [31:0]   pc;
    logic [31:0]   pc_next;
    logic          out_free;
    logic          capture;
    fetch_packet_t pkt_next;

    // the cache always looks at the current pc.
    assign lookup_addr = pc;

    // output register is free when empty or draining this cycle.
    assign out_free = !fetch_valid || fetch_ready;

    // a redirect squashes whatever the hit path offers.
    assign capture = lookup_hit && out_free && !redirect_valid;

    assign pc_next = redirect_valid ? redirect_pc : pc + 32'd4;

    always_comb begin
        pkt_next.pc    = pc;
        pkt_next.inst  = lookup_inst;
        pkt_next.fault = lookup_fault;
    end

    // pc moves only on a capture or a redirect.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect_valid || capture) begin
            pc <= pc_next;
        end
    end

    // valid of the output register.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else if (redirect_valid) begin
            // old path packet is dropped even when stalled.
            fetch_valid <= 1'b0;
        end else if (capture) begin
            fetch_valid <= 1'b1;
        end else if (fetch_ready) begin
            fetch_valid <= 1'b0;
        end
    end

    // payload holds until the next capture.
    always_ff @(posedge clk) begin
        if (capture) begin
            fetch_pkt <= pkt_next;
        end
    end

endmodule

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache #(
    parameter int unsigned LINE_BYTES = 16,
    parameter int unsigned NUM_LINES  = 8
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // lookup from the fetch unit.
    input  wire logic [31:0]             lookup_addr,
    output logic                         lookup_hit,
    output logic [31:0]                  lookup_inst,
    output logic                         lookup_fault,

    // refill toward the AXI master.
    output logic                         refill_req,
    output logic [31:0]                  refill_addr,
    input  wire logic                    refill_done,
    input  wire logic [LINE_BYTES*8-1:0] refill_line,
    input  wire logic                    refill_fault
);
    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int INDEX_W  = $clog2(NUM_LINES);
    localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;

    logic [LINE_BYTES*8-1:0] data_mem [NUM_LINES];
    logic [TAG_W-1:0]        tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0]    line_valid;

    logic [INDEX_W-1:0]      look_index;
    logic [TAG_W-1:0]        look_tag;
    logic [OFFSET_W-1:0]     word_sel;
    logic [31:0]             look_base;
    logic [LINE_BYTES*8-1:0] look_line;
    logic [INDEX_W-1:0]      fill_index;
    logic [TAG_W-1:0]        fill_tag;
    logic                    tag_hit;
    logic                    fault_pend;
    logic [31:0]             fault_addr;
    logic                    fault_hit;
    logic                    start_miss;

    assign look_index = lookup_addr[OFFSET_W +: INDEX_W];
    assign look_tag   = lookup_addr[31 -: TAG_W];
    assign word_sel   = lookup_addr[OFFSET_W-1:0] >> 2;
    assign look_base  = {lookup_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign fill_index = refill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag   = refill_addr[31 -: TAG_W];

    assign look_line = data_mem[look_index];
    assign tag_hit   = line_valid[look_index] && (tag_mem[look_index] == look_tag);

    // one-shot hit for the word whose refill failed.
    assign fault_hit = fault_pend && (lookup_addr == fault_addr);

    assign lookup_hit   = tag_hit || fault_hit;
    assign lookup_fault = fault_hit;
    assign lookup_inst  = fault_hit ? 32'h0 : look_line[word_sel*32 +: 32];

    // new refill only when none is running.
    assign start_miss = !refill_req && !lookup_hit && !refill_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_valid <= '0;
            refill_req <= 1'b0;
            fault_pend <= 1'b0;
        end else if (refill_done) begin
            refill_req             <= 1'b0;
            line_valid[fill_index] <= !refill_fault;
            // flag it only if the pc still sits in the failed line.
            fault_pend             <= refill_fault && (look_base == refill_addr);
        end else begin
            if (fault_pend && !fault_hit) begin
                fault_pend <= 1'b0;
            end
            if (start_miss) begin
                refill_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            refill_addr <= look_base;
        end
        if (refill_done) begin
            fault_addr <= lookup_addr;
        end
        if (refill_done && !refill_fault) begin
            data_mem[fill_index] <= refill_line;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

endmodule

`default_nettype wire

//--- design/axi_refill.sv
`timescale 1ns/1ns
`default_nettype none

module axi_refill #(
    parameter int unsigned LINE_BYTES = 16
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // request from the cache.
    input  wire logic                    refill_req,
    input  wire logic [31:0]             refill_addr,
    output logic                         refill_done,
    output logic [LINE_BYTES*8-1:0]      refill_line,
    output logic                         refill_fault,

    // AXI read address.
    output logic                         arvalid,
    input  wire logic                    arready,
    output fetch_pkg::axi_ar_t           ar,

    // AXI read data.
    input  wire logic                    rvalid,
    output logic                         rready,
    input  wire fetch_pkg::axi_r_t       r
);
    import fetch_pkg::*;

    localparam int WORDS  = LINE_BYTES / 4;
    localparam int BEAT_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DONE
    } state_t;

    state_t            state;
    logic [BEAT_W-1:0] beat;
    logic              burst_mode;
    logic              in_sdram;
    logic              start;
    logic              ar_fire;
    logic              r_fire;
    logic              last_beat;

    assign in_sdram = (refill_addr[31:28] >= SDRAM_BASE_NIBBLE) &&
                      (refill_addr[31:28] <= SDRAM_END_NIBBLE);

    assign start   = (state == IDLE) && refill_req;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // burst ends on rlast, single beats end on the count.
    assign last_beat = burst_mode ? r.last : (beat == BEAT_W'(WORDS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            refill_done  <= 1'b0;
            refill_fault <= 1'b0;
            burst_mode   <= 1'b0;
            beat         <= '0;
        end else begin
            refill_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (refill_req) begin
                        arvalid      <= 1'b1;
                        burst_mode   <= in_sdram;
                        refill_fault <= 1'b0;
                        beat         <= '0;
                        state        <= ADDR;
                    end
                end
                ADDR: begin
                    if (ar_fire) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (r_fire) begin
                        beat <= beat + 1'b1;
                        if (r.resp != AXI_RESP_OKAY) begin
                            refill_fault <= 1'b1;
                        end
                        if (last_beat) begin
                            rready      <= 1'b0;
                            refill_done <= 1'b1;
                            state       <= DONE;
                        end else if (!burst_mode) begin
                            // next single-beat request.
                            rready  <= 1'b0;
                            arvalid <= 1'b1;
                            state   <= ADDR;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ar.addr  <= refill_addr;
            ar.id    <= '0;
            ar.size  <= AXI_SIZE_WORD;
            ar.len   <= in_sdram ? 8'(WORDS - 1) : 8'd0;
            ar.burst <= in_sdram ? AXI_BURST_INCR : AXI_BURST_FIXED;
        end else if (r_fire && !burst_mode) begin
            ar.addr <= ar.addr + 32'd4;
        end
        if (r_fire) begin
            refill_line[beat*32 +: 32] <= r.data;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter int unsigned LINE_BYTES = 16,
    parameter int unsigned NUM_LINES  = 8,
    parameter logic [31:0] RESET_PC   = 32'h3000_0000
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // decode side.
    output logic                       fetch_valid,
    input  wire logic                  fetch_ready,
    output fetch_pkg::fetch_packet_t   fetch_pkt,

    // execute side.
    input  wire logic                  redirect_valid,
    input  wire logic [31:0]           redirect_pc,

    // AXI read master.
    output logic                       arvalid,
    input  wire logic                  arready,
    output fetch_pkg::axi_ar_t         ar,
    input  wire logic                  rvalid,
    output logic                       rready,
    input  wire fetch_pkg::axi_r_t     r
);
    logic [31:0]             lookup_addr;
    logic                    lookup_hit;
    logic [31:0]             lookup_inst;
    logic                    lookup_fault;
    logic                    refill_req;
    logic [31:0]             refill_addr;
    logic                    refill_done;
    logic [LINE_BYTES*8-1:0] refill_line;
    logic                    refill_fault;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_ready    (fetch_ready),
        .fetch_valid    (fetch_valid),
        .fetch_pkt      (fetch_pkt),
        .lookup_addr    (lookup_addr),
        .lookup_hit     (lookup_hit),
        .lookup_inst    (lookup_inst),
        .lookup_fault   (lookup_fault)
    );

    icache #(
        .LINE_BYTES (LINE_BYTES),
        .NUM_LINES  (NUM_LINES)
    ) u_icache (
        .clk          (clk),
        .rst          (rst),
        .lookup_addr  (lookup_addr),
        .lookup_hit   (lookup_hit),
        .lookup_inst  (lookup_inst),
        .lookup_fault (lookup_fault),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .refill_fault (refill_fault)
    );

    axi_refill #(
        .LINE_BYTES (LINE_BYTES)
    ) u_axi_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .refill_fault (refill_fault),
        .arvalid      (arvalid),
        .arready      (arready),
        .ar           (ar),
        .rvalid       (rvalid),
        .rready       (rready),
        .r            (r)
    );

endmodule

`default_nettype wire

//--- test/fetch_sva.sv
`timescale 1ns/1ns
`default_nettype none

// generic valid/ready checks for the AR channel and the decode output.
module fetch_sva #(
    parameter int W = 32
) (
    input wire logic         clk,
    input wire logic         rst,
    input wire logic         valid,
    input wire logic         ready,
    input wire logic [W-1:0] data,
    input wire logic         flush
);

    // a stalled transfer keeps valid and its payload.
    property hold_while_stalled;
        @(posedge clk) disable iff (rst)
            valid && !ready && !flush |=> valid && $stable(data);
    endproperty

    property payload_known;
        @(posedge clk) disable iff (rst) valid |-> !$isunknown(data);
    endproperty

    a_hold: assert property (hold_while_stalled)
        else $error("payload or valid changed while stalled");
    a_known: assert property (payload_known)
        else $error("payload is unknown while valid");

endmodule

bind axi_refill fetch_sva #(
    .W ($bits(fetch_pkg::axi_ar_t))
) u_ar_sva (
    .clk   (clk),
    .rst   (rst),
    .valid (arvalid),
    .ready (arready),
    .data  (ar),
    .flush (1'b0)
);

bind fetch_unit fetch_sva #(
    .W ($bits(fetch_pkg::fetch_packet_t))
) u_out_sva (
    .clk   (clk),
    .rst   (rst),
    .valid (fetch_valid),
    .ready (fetch_ready),
    .data  (fetch_pkt),
    .flush (redirect_valid)
);

`default_nettype wire

//--- test/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int          LINE_BYTES = 16;
    localparam int          WORDS      = LINE_BYTES / 4;
    localparam logic [31:0] RESET_PC   = 32'h3000_0000;
    localparam int          MAX_SEGS   = 32;

    logic          clk;
    logic          rst;
    logic          fetch_valid;
    logic          fetch_ready;
    fetch_packet_t fetch_pkt;
    logic          redirect_valid;
    logic [31:0]   redirect_pc;
    logic          arvalid;
    logic          arready;
    axi_ar_t       ar;
    logic          rvalid;
    logic          rready;
    axi_r_t        r;

    logic [31:0] td [0:3*MAX_SEGS-1];
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    int          got;
    int          seg_ar;
    logic [31:0] exp_pc;
    logic [27:0] seg_lo;
    logic [27:0] seg_hi;

    // memory model state.
    logic        busy;
    logic [31:0] mem_addr;
    int          beats_left;
    logic        incr;
    int          ar_delay;
    int          r_delay;
    logic        r_taken;
    logic [31:0] last_ar;

    fetch_top #(
        .LINE_BYTES (LINE_BYTES),
        .NUM_LINES  (8),
        .RESET_PC   (RESET_PC)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready),
        .fetch_pkt      (fetch_pkt),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .arvalid        (arvalid),
        .arready        (arready),
        .ar             (ar),
        .rvalid         (rvalid),
        .rready         (rready),
        .r              (r)
    );

    always #5 clk = !clk;

    // word stored at an address.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[23:0], addr[31:24]} ^ 32'hc3a5_0f96;
    endfunction

    // run length limit.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, %0d errors so far", cycles, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // accepted packets, AR requests and R beats at the rising edge.
    always @(posedge clk) begin
        if (!rst && rready && !busy) begin
            $display("rready is high while no read beat is outstanding");
            errors = errors + 1;
        end
        if (!rst && fetch_valid && fetch_ready) begin
            checks = checks + 1;
            if (fetch_pkt.pc !== exp_pc) begin
                $display("MISMATCH fetch_pkt.pc got %h exp %h", fetch_pkt.pc, exp_pc);
                errors = errors + 1;
            end
            if (fetch_pkt.fault !== (exp_pc[31:28] == 4'h8)) begin
                $display("MISMATCH fetch_pkt.fault got %h exp %h at pc %h",
                         fetch_pkt.fault, exp_pc[31:28] == 4'h8, exp_pc);
                errors = errors + 1;
            end
            if (exp_pc[31:28] != 4'h8 && fetch_pkt.inst !== mem_word(exp_pc)) begin
                $display("MISMATCH fetch_pkt.inst got %h exp %h", fetch_pkt.inst,
                         mem_word(exp_pc));
                errors = errors + 1;
            end
            exp_pc = exp_pc + 32'd4;
            got    = got + 1;
        end
        if (!rst && arvalid && arready) begin
            checks = checks + 1;
            // four byte beats.
            if (ar.size !== 3'd2) begin
                $display("MISMATCH ar.size got %h exp %h", ar.size, 3'd2);
                errors = errors + 1;
            end
            if (ar.addr[31:28] == 4'hA || ar.addr[31:28] == 4'hB) begin
                if (ar.burst !== AXI_BURST_INCR || ar.len !== 8'(WORDS - 1)) begin
                    $display("MISMATCH ar.burst/len got %h/%h exp %h/%h", ar.burst, ar.len,
                             AXI_BURST_INCR, 8'(WORDS - 1));
                    errors = errors + 1;
                end
            end else begin
                if (ar.burst !== AXI_BURST_FIXED || ar.len !== 8'd0) begin
                    $display("MISMATCH ar.burst/len got %h/%h exp %h/%h", ar.burst, ar.len,
                             AXI_BURST_FIXED, 8'd0);
                    errors = errors + 1;
                end
                if (ar.addr[3:0] != 4'h0 && ar.addr !== last_ar + 32'd4) begin
                    $display("MISMATCH ar.addr got %h exp %h", ar.addr, last_ar + 32'd4);
                    errors = errors + 1;
                end
            end
            if (ar.addr[31:4] >= seg_lo && ar.addr[31:4] <= seg_hi) begin
                seg_ar = seg_ar + 1;
            end
            last_ar    = ar.addr;
            mem_addr   = ar.addr;
            beats_left = ar.len + 1;
            incr       = (ar.burst == AXI_BURST_INCR);
            busy       = 1'b1;
        end
        if (!rst && rvalid && rready) begin
            r_taken    = 1'b1;
            beats_left = beats_left - 1;
            if (incr) begin
                mem_addr = mem_addr + 32'd4;
            end
            if (beats_left == 0) begin
                busy = 1'b0;
            end
        end
    end

    // memory responses with random delays.
    always @(negedge clk) begin
        arready = 1'b0;
        if (!busy && arvalid) begin
            if (ar_delay == 0) begin
                arready  = 1'b1;
                ar_delay = $urandom % 4;
            end else begin
                ar_delay = ar_delay - 1;
            end
        end
        // a beat stays on the bus until it is taken.
        if (!rvalid || r_taken) begin
            r_taken = 1'b0;
            rvalid  = 1'b0;
            if (busy) begin
                if (r_delay == 0) begin
                    rvalid  = 1'b1;
                    r.data  = mem_word(mem_addr);
                    r.resp  = (mem_addr[31:28] == 4'h8) ? 2'b10 : AXI_RESP_OKAY;
                    r.last  = (beats_left == 1);
                    r.id    = '0;
                    r_delay = $urandom % 4;
                end else begin
                    r_delay = r_delay - 1;
                end
            end
        end
    end

    task automatic run_segment(input logic [31:0] target, input int count,
                               input logic want_ar, input logic use_redirect);
        logic [31:0] last_pc;
        @(negedge clk);
        fetch_ready = 1'b0;
        last_pc     = target + 32'(4 * (count - 1));
        seg_lo      = target[31:4];
        seg_hi      = last_pc[31:4];
        seg_ar      = 0;
        got         = 0;
        exp_pc      = target;
        if (use_redirect) begin
            redirect_valid = 1'b1;
            redirect_pc    = target;
            @(negedge clk);
            redirect_valid = 1'b0;
        end
        while (got < count) begin
            fetch_ready = ($urandom % 4) != 0;
            @(negedge clk);
        end
        fetch_ready = 1'b0;
        if (want_ar && seg_ar == 0) begin
            $display("no AR request seen for the lines of target %h", target);
            errors = errors + 1;
        end
        if (!want_ar && seg_ar != 0) begin
            $display("%0d AR requests seen for target %h, its lines should be cached",
                     seg_ar, target);
            errors = errors + 1;
        end
    endtask

    initial begin
        int nsegs;
        int total;
        void'($urandom(32'he7bd_23d7));
        clk            = 1'b0;
        rst            = 1'b1;
        fetch_ready    = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        arready        = 1'b0;
        rvalid         = 1'b0;
        r              = '0;
        errors         = 0;
        checks         = 0;
        cycles         = 0;
        limit          = 0;
        busy           = 1'b0;
        ar_delay       = 0;
        r_delay        = 0;
        r_taken        = 1'b0;
        last_ar        = '0;
        exp_pc         = RESET_PC;
        seg_lo         = '0;
        seg_hi         = '0;
        for (int i = 0; i < 3 * MAX_SEGS; i++) begin
            td[i] = '0;
        end
        $readmemh("test/fetch_testdata.txt", td);
        nsegs = 0;
        total = 0;
        // a zero packet count ends the list.
        while (nsegs < MAX_SEGS && td[3*nsegs+1] != 0) begin
            total = total + td[3*nsegs+1];
            nsegs = nsegs + 1;
        end
        if (nsegs == 0) begin
            $display("no stimulus lines read from the data file");
            errors = errors + 1;
        end
        limit = 200 * (total + 1);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < nsegs; i++) begin
            run_segment(td[3*i], td[3*i+1], td[3*i+2] != 0, i != 0);
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_top.f
design/fetch_pkg.sv
design/fetch_unit.sv
design/icache.sv
design/axi_refill.sv
design/fetch_top.sv
test/fetch_sva.sv
test/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - files:
      - design/fetch_pkg.sv
      - design/fetch_unit.sv
      - design/icache.sv
      - design/axi_refill.sv
      - design/fetch_top.sv
  - target: test
    files:
      - test/fetch_sva.sv
      - test/fetch_tb.sv

//--- test/fetch_testdata.txt
// columns, all hex: redirect target, packets to check, AR requests expected (1) or not (0)
// the first line is the reset path and is taken without a redirect
30000000 08 1
a0000100 08 1
40000040 06 1
a0000100 08 0
80000200 02 1
80000200 01 1
50000008 0a 1
40000040 06 0
b00003f8 0c 1
30000000 04 1
